// ==== common/buf_ctrl_pkg.sv ====
package buf_ctrl_pkg;

    // Tile geometry. One line is one row or one column of the tile.
    localparam int TILE_DIM = 4;
    localparam int IDX_W    = $clog2(TILE_DIM);

    // Two banks per buffer. The pointers carry one extra wrap bit.
    localparam int NUM_BANKS = 2;
    localparam int PTR_W     = 2;

    // Line index within a tile.
    typedef logic [IDX_W-1:0] idx_t;

    // Bank pointer. Bit 0 selects the bank, bit 1 tells full from empty.
    typedef logic [PTR_W-1:0] ptr_t;

    // Highest line index. A row or column walk ends here.
    localparam idx_t LAST_IDX = idx_t'(TILE_DIM - 1);

    // Orientation of a line, used both for storing and for reading.
    typedef enum logic {
        LAYOUT_COL = 1'b0,  // A line carries one column of the tile.
        LAYOUT_ROW = 1'b1   // A line carries one row of the tile.
    } layout_e;

endpackage

// ==== common/mat_types_pkg.sv ====
package mat_types_pkg;

    // Element and accumulator widths.
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 20;  // Four products of 9 by 8 signed bits need 19.

    // Activations are unsigned, weights are two's complement.
    typedef logic [ELEM_W-1:0]        act_t;
    typedef logic signed [ELEM_W-1:0] wgt_t;

    // One line holds a full row or column of a tile.
    // Element k sits at index k, so line[0] is the element in row or column 0.
    typedef act_t [buf_ctrl_pkg::TILE_DIM-1:0] act_line_t;
    typedef wgt_t [buf_ctrl_pkg::TILE_DIM-1:0] wgt_line_t;

    // Dot product of one row of A with one column of B.
    typedef logic signed [ACC_W-1:0] acc_t;

    // Product of one activation and one weight at accumulator width.
    // The activation is zero extended, the weight sign extended.
    function automatic acc_t mul_elem(act_t act, wgt_t wgt);
        acc_t act_ext;
        acc_t wgt_ext;
        act_ext = acc_t'(act);
        wgt_ext = acc_t'(wgt);
        return act_ext * wgt_ext;
    endfunction

    // Sum of the element products of one A line and one B line.
    function automatic acc_t dot_line(act_line_t a_line, wgt_line_t b_line);
        acc_t sum;
        sum = '0;
        for (int k = 0; k < buf_ctrl_pkg::TILE_DIM; k++) begin
            sum = sum + mul_elem(a_line[k], b_line[k]);
        end
        return sum;
    endfunction

endpackage

// ==== common/line_stream_if.sv ====
interface line_stream_if #(
    parameter type line_t = logic [31:0]
);

    logic                  valid;   // Source has a line.
    logic                  ready;   // Sink can take a line.
    logic                  last;    // Fourth line of a tile.
    buf_ctrl_pkg::idx_t    index;   // Row or column number of this line.
    buf_ctrl_pkg::layout_e layout;  // Whether this line is a row or a column.
    line_t                 data;

    modport source (
        output valid,
        output last,
        output index,
        output layout,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  last,
        input  index,
        input  layout,
        input  data,
        output ready
    );

endinterface

// ==== tile_buffer/tile_buffer.sv ====
module tile_buffer #(
    parameter type                   line_t    = mat_types_pkg::act_line_t,
    parameter buf_ctrl_pkg::layout_e read_axis = buf_ctrl_pkg::LAYOUT_ROW
) (
    input  logic               clk,
    input  logic               rstn,

    // Incoming line stream.
    line_stream_if.sink        wr,

    // Read side towards the multiplier.
    input  buf_ctrl_pkg::idx_t rd_index,
    output line_t              rd_line,
    output logic               tile_valid,
    input  logic               rd_release
);

    // Bank pointers. Bit 0 names the bank, bit 1 is the lap bit.
    buf_ctrl_pkg::ptr_t wr_ptr;
    buf_ctrl_pkg::ptr_t rd_ptr;

    logic full;     // Both banks hold complete tiles.
    logic empty;    // No complete tile is waiting.
    logic wr_fire;  // A line is accepted on this edge.
    logic wr_bank;
    logic rd_bank;

    // Tile storage is always kept as rows. Element (r, c) of bank b is bank[b][r][c].
    line_t bank [buf_ctrl_pkg::NUM_BANKS][buf_ctrl_pkg::TILE_DIM];

    assign wr_bank = wr_ptr[0];
    assign rd_bank = rd_ptr[0];

    // Same lap bit and same bank means nothing is stored.
    // Different lap bit on the same bank means both banks are taken.
    assign full  = (wr_ptr[1] ^ rd_ptr[1]) & (wr_ptr[0] == rd_ptr[0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr.ready   = ~full;
    assign tile_valid = ~empty;

    assign wr_fire = wr.valid & wr.ready;

    // Pointer update.
    // The write bank flips when the last line of a tile is taken.
    // The read bank flips when the multiplier is done with it.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire && wr.last) begin
                wr_ptr <= wr_ptr + buf_ctrl_pkg::ptr_t'(1);  // Tile complete.
            end
            if (rd_release) begin
                rd_ptr <= rd_ptr + buf_ctrl_pkg::ptr_t'(1);
            end
        end
    end

    // Line write.
    // A row line lands as one whole row. A column line is spread over the
    // rows, element r going to row r at column index.
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (wr.layout == buf_ctrl_pkg::LAYOUT_ROW) begin
                bank[wr_bank][wr.index] <= wr.data;
            end else begin
                for (int r = 0; r < buf_ctrl_pkg::TILE_DIM; r++) begin
                    bank[wr_bank][r][wr.index] <= wr.data[r];
                end
            end
        end
    end

    // Line read. The orientation is fixed for each instance.
    generate
        if (read_axis == buf_ctrl_pkg::LAYOUT_ROW) begin : g_read_row
            // Row rd_index is one stored line.
            assign rd_line = bank[rd_bank][rd_index];
        end else begin : g_read_col
            // Column rd_index is gathered from all rows.
            always_comb begin
                for (int r = 0; r < buf_ctrl_pkg::TILE_DIM; r++) begin
                    rd_line[r] = bank[rd_bank][r][rd_index];
                end
            end
        end
    endgenerate

endmodule

// ==== logic/tile_multiplier.sv ====
module tile_multiplier (
    input  logic                      clk,
    input  logic                      rstn,

    // Read side of the A buffer, read as rows.
    input  logic                      a_tile_valid,
    input  mat_types_pkg::act_line_t  a_line,
    output buf_ctrl_pkg::idx_t        a_index,

    // Read side of the B buffer, read as columns.
    input  logic                      b_tile_valid,
    input  mat_types_pkg::wgt_line_t  b_line,
    output buf_ctrl_pkg::idx_t        b_index,

    // Frees the read bank of both buffers.
    output logic                      rd_release,

    // Result stream.
    output logic                      res_valid,
    input  logic                      res_ready,
    output mat_types_pkg::acc_t       res_data,
    output buf_ctrl_pkg::idx_t        res_row,
    output buf_ctrl_pkg::idx_t        res_col,
    output logic                      res_last
);

    buf_ctrl_pkg::idx_t  i_cnt;      // Row of A, outer loop.
    buf_ctrl_pkg::idx_t  j_cnt;      // Column of B, inner loop.
    logic                issue;      // A pair enters the pipeline on this edge.
    logic                slot_free;  // The result register can take a new value.
    logic                last_pair;
    mat_types_pkg::acc_t dot_sum;

    // Both operand lines come straight from the buffers in this cycle.
    assign a_index = i_cnt;
    assign b_index = j_cnt;

    assign dot_sum = mat_types_pkg::dot_line(a_line, b_line);

    assign last_pair = (i_cnt == buf_ctrl_pkg::LAST_IDX) && (j_cnt == buf_ctrl_pkg::LAST_IDX);

    // The held result leaves on this edge, or there is none.
    assign slot_free = ~res_valid | res_ready;
    assign issue     = a_tile_valid & b_tile_valid & slot_free;

    // Both tiles are fully read once pair (3, 3) issues.
    assign rd_release = issue & last_pair;

    // Pair counter. Stops whenever nothing issues.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            i_cnt <= '0;
            j_cnt <= '0;
        end else if (issue) begin
            j_cnt <= j_cnt + buf_ctrl_pkg::idx_t'(1);  // Wraps to 0 after 3.
            if (j_cnt == buf_ctrl_pkg::LAST_IDX) begin
                i_cnt <= i_cnt + buf_ctrl_pkg::idx_t'(1);
            end
        end
    end

    // Result valid flag.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else if (issue) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;  // Taken and nothing new behind it.
        end
    end

    // Result payload. Holds while the consumer stalls.
    always_ff @(posedge clk) begin
        if (issue) begin
            res_data <= dot_sum;
            res_row  <= i_cnt;
            res_col  <= j_cnt;
            res_last <= last_pair;
        end
    end

endmodule

// ==== logic/matmul_tile_top.sv ====
module matmul_tile_top (
    input  logic                      clk,
    input  logic                      rstn,

    // Activation line stream.
    input  logic                      a_valid,
    output logic                      a_ready,
    input  logic                      a_last,
    input  buf_ctrl_pkg::idx_t        a_index,
    input  buf_ctrl_pkg::layout_e     a_layout,
    input  mat_types_pkg::act_line_t  a_data,

    // Weight line stream.
    input  logic                      b_valid,
    output logic                      b_ready,
    input  logic                      b_last,
    input  buf_ctrl_pkg::idx_t        b_index,
    input  buf_ctrl_pkg::layout_e     b_layout,
    input  mat_types_pkg::wgt_line_t  b_data,

    // Result stream.
    output logic                      res_valid,
    input  logic                      res_ready,
    output mat_types_pkg::acc_t       res_data,
    output buf_ctrl_pkg::idx_t        res_row,
    output buf_ctrl_pkg::idx_t        res_col,
    output logic                      res_last
);

    line_stream_if #(.line_t(mat_types_pkg::act_line_t)) a_stream ();
    line_stream_if #(.line_t(mat_types_pkg::wgt_line_t)) b_stream ();

    logic                     a_tile_valid;
    logic                     b_tile_valid;
    buf_ctrl_pkg::idx_t       a_rd_index;
    buf_ctrl_pkg::idx_t       b_rd_index;
    mat_types_pkg::act_line_t a_rd_line;
    mat_types_pkg::wgt_line_t b_rd_line;
    logic                     rd_release;

    // Bundle the plain ports into the internal streams.
    assign a_stream.valid  = a_valid;
    assign a_stream.last   = a_last;
    assign a_stream.index  = a_index;
    assign a_stream.layout = a_layout;
    assign a_stream.data   = a_data;
    assign a_ready         = a_stream.ready;

    assign b_stream.valid  = b_valid;
    assign b_stream.last   = b_last;
    assign b_stream.index  = b_index;
    assign b_stream.layout = b_layout;
    assign b_stream.data   = b_data;
    assign b_ready         = b_stream.ready;

    // A is read by rows, B by columns.
    tile_buffer #(
        .line_t    (mat_types_pkg::act_line_t),
        .read_axis (buf_ctrl_pkg::LAYOUT_ROW)
    ) u_a_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (a_stream.sink),
        .rd_index   (a_rd_index),
        .rd_line    (a_rd_line),
        .tile_valid (a_tile_valid),
        .rd_release (rd_release)
    );

    tile_buffer #(
        .line_t    (mat_types_pkg::wgt_line_t),
        .read_axis (buf_ctrl_pkg::LAYOUT_COL)
    ) u_b_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (b_stream.sink),
        .rd_index   (b_rd_index),
        .rd_line    (b_rd_line),
        .tile_valid (b_tile_valid),
        .rd_release (rd_release)
    );

    tile_multiplier u_multiplier (
        .clk          (clk),
        .rstn         (rstn),
        .a_tile_valid (a_tile_valid),
        .a_line       (a_rd_line),
        .a_index      (a_rd_index),
        .b_tile_valid (b_tile_valid),
        .b_line       (b_rd_line),
        .b_index      (b_rd_index),
        .rd_release   (rd_release),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res_data     (res_data),
        .res_row      (res_row),
        .res_col      (res_col),
        .res_last     (res_last)
    );

endmodule

// ==== testbench/matmul_tile_chk.sv ====
module matmul_tile_chk (
    input logic                clk,
    input logic                rstn,
    input logic                a_ready,
    input logic                b_ready,
    input logic                res_valid,
    input logic                res_ready,
    input mat_types_pkg::acc_t res_data,
    input buf_ctrl_pkg::idx_t  res_row,
    input buf_ctrl_pkg::idx_t  res_col,
    input logic                res_last
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] exp_pos;  // Row-major position of the next result in its tile.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            exp_pos <= '0;
        end else if (res_valid && res_ready) begin
            exp_pos <= exp_pos + 4'd1;  // Wraps to 0 after result (3, 3).
        end
    end

    // In the first cycle out of reset no result is pending and both line streams are open.
    a_reset_state: assert property (@(posedge clk)
        $rose(rstn) |-> !res_valid && a_ready && b_ready)
        else $error("Result or line stream not idle right after reset");

    a_res_hold: assert property (@(posedge clk) disable iff (!rstn)
        res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_row)
            && $stable(res_col) && $stable(res_last))
        else $error("Result stream changed while stalled");

    a_res_order: assert property (@(posedge clk) disable iff (!rstn)
        res_valid |-> {res_row, res_col} == exp_pos)
        else $error("Result out of row and column order");

    // The sixteenth result of each tile carries res_last and no other result does.
    a_res_last: assert property (@(posedge clk) disable iff (!rstn)
        res_valid |-> res_last == (exp_pos == 4'd15))
        else $error("res_last does not match result (3, 3)");

endmodule

// ==== testbench/tb_matmul_tile.sv ====
module tb_matmul_tile;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DRIVE_DELAY    = 5;
    localparam int          TIMEOUT_CYCLES = 500;
    localparam int unsigned RAND_SEED      = 32'haccf6de2;
    localparam int          MODE_RANDOM    = 0;
    localparam int          MODE_LOW       = 1;
    localparam int          MODE_HIGH      = 2;
    localparam int          WAIT_DRAIN     = 0;
    localparam int          WAIT_STALL     = 1;
    localparam int          WAIT_SENT      = 2;

    typedef logic [35:0] line_word_t;  // Bits are last, layout, index, then the line data.

    logic                     clk = 1'b0;
    logic                     rstn;
    logic                     a_valid;
    logic                     a_ready;
    logic                     a_last;
    buf_ctrl_pkg::idx_t       a_index;
    buf_ctrl_pkg::layout_e    a_layout;
    mat_types_pkg::act_line_t a_data;
    logic                     b_valid;
    logic                     b_ready;
    logic                     b_last;
    buf_ctrl_pkg::idx_t       b_index;
    buf_ctrl_pkg::layout_e    b_layout;
    mat_types_pkg::wgt_line_t b_data;
    logic                     res_valid;
    logic                     res_ready;
    mat_types_pkg::acc_t      res_data;
    buf_ctrl_pkg::idx_t       res_row;
    buf_ctrl_pkg::idx_t       res_col;
    logic                     res_last;

    line_word_t a_line_q[$];
    line_word_t b_line_q[$];
    int         exp_data_q[$];   // Expected dot products in arrival order.
    int         exp_pos_q[$];    // Matching row * 4 + column.
    int         tiles_in [2];    // Tiles accepted on the A and B streams.
    int         ready_mode;

    always #50 clk = ~clk;

    matmul_tile_top u_matmul_tile_top (.*);

    bind matmul_tile_top matmul_tile_chk u_chk (.*);

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
            $time, name, got, exp));
    endtask

    task automatic drive_line(input bit is_b, input logic valid, input line_word_t word);
        if (is_b) begin
            b_valid  = valid;
            b_last   = word[35];
            b_layout = buf_ctrl_pkg::layout_e'(word[34]);
            b_index  = word[33:32];
            b_data   = word[31:0];
        end else begin
            a_valid  = valid;
            a_last   = word[35];
            a_layout = buf_ctrl_pkg::layout_e'(word[34]);
            a_index  = word[33:32];
            a_data   = word[31:0];
        end
    endtask

    // Random A and B tiles, their product and the lines that carry them.
    task automatic load_tiles(input int count, input buf_ctrl_pkg::layout_e lay);
        logic [7:0]        a_elem [4][4];
        logic signed [7:0] b_elem [4][4];
        line_word_t        a_word;
        line_word_t        b_word;
        int                sum;
        for (int t = 0; t < count; t++) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    a_elem[r][c] = 8'($urandom);
                    b_elem[r][c] = 8'($urandom);
                end
            end
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    sum = 0;
                    for (int k = 0; k < 4; k++) begin
                        sum += int'(a_elem[i][k]) * int'(b_elem[k][j]);  // Unsigned by signed.
                    end
                    exp_data_q.push_back(sum);
                    exp_pos_q.push_back(i * 4 + j);
                end
            end
            for (int n = 0; n < 4; n++) begin
                a_word[35]    = (n == 3);
                a_word[34]    = lay;
                a_word[33:32] = 2'(n);
                b_word[35:32] = a_word[35:32];
                for (int k = 0; k < 4; k++) begin
                    if (lay == buf_ctrl_pkg::LAYOUT_ROW) begin
                        a_word[8*k +: 8] = a_elem[n][k];
                        b_word[8*k +: 8] = b_elem[n][k];
                    end else begin
                        a_word[8*k +: 8] = a_elem[k][n];  // Element k of column n.
                        b_word[8*k +: 8] = b_elem[k][n];
                    end
                end
                a_line_q.push_back(a_word);
                b_line_q.push_back(b_word);
            end
        end
    endtask

    task automatic send_lines(input bit is_b);
        line_word_t word;
        int         waited;
        @(posedge clk);
        #DRIVE_DELAY;
        while ((is_b ? b_line_q.size() : a_line_q.size()) > 0) begin
            word = is_b ? b_line_q[0] : a_line_q[0];
            drive_line(is_b, 1'b1, word);
            waited = 0;
            @(negedge clk);
            while (!(is_b ? b_ready : a_ready)) begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    fail_run($sformatf("Line stream %s never took its line.", is_b ? "B" : "A"));
                end
                @(negedge clk);
            end
            @(posedge clk);  // The line transfers on this edge.
            #DRIVE_DELAY;
            if (is_b) void'(b_line_q.pop_front());
            else void'(a_line_q.pop_front());
            if (word[35]) tiles_in[is_b] = tiles_in[is_b] + 1;
        end
        drive_line(is_b, 1'b0, '0);
    endtask

    task automatic check_result();
        int exp_data;
        int exp_pos;
        if (exp_data_q.size() == 0) fail_run("A result arrived with no tile pair behind it.");
        exp_data = exp_data_q.pop_front();
        exp_pos  = exp_pos_q.pop_front();
        assert (int'(res_data) == exp_data)
            else report_mismatch("res_data", int'(res_data), exp_data);
        assert (int'(res_row) == exp_pos / 4)
            else report_mismatch("res_row", int'(res_row), exp_pos / 4);
        assert (int'(res_col) == exp_pos % 4)
            else report_mismatch("res_col", int'(res_col), exp_pos % 4);
        assert (res_last == (exp_pos == 15))
            else report_mismatch("res_last", int'(res_last), int'(exp_pos == 15));
    endtask

    // Drives res_ready each cycle and checks every result handshake.
    task automatic sink_results();
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (ready_mode == MODE_RANDOM) res_ready = 1'($urandom);
            else res_ready = (ready_mode == MODE_HIGH);
            @(negedge clk);
            if (res_valid && res_ready) check_result();
        end
    endtask

    function automatic bit condition_met(input int what);
        case (what)
            WAIT_DRAIN: return exp_data_q.size() == 0 && !res_valid;
            WAIT_STALL: return !a_ready && !b_ready && tiles_in[0] == 2 && tiles_in[1] == 2;
            default:    return a_line_q.size() == 0 && b_line_q.size() == 0;
        endcase
    endfunction

    task automatic wait_for(input int what, input string what_text);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!condition_met(what)) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_run($sformatf("Timed out waiting for %s.", what_text));
            end
            @(negedge clk);
        end
    endtask

    initial begin
        rstn = 1'b0;
        drive_line(1'b0, 1'b0, '0);
        drive_line(1'b1, 1'b0, '0);
        res_ready  = 1'b0;
        ready_mode = MODE_LOW;
        tiles_in   = '{0, 0};
        void'($urandom(RAND_SEED));
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        fork
            sink_results();
        join_none
        ready_mode = MODE_RANDOM;
        load_tiles(2, buf_ctrl_pkg::LAYOUT_ROW);
        fork
            send_lines(1'b0);
            send_lines(1'b1);
        join
        wait_for(WAIT_DRAIN, "the results of the row-loaded tiles");
        load_tiles(2, buf_ctrl_pkg::LAYOUT_COL);
        fork
            send_lines(1'b0);
            send_lines(1'b1);
        join
        wait_for(WAIT_DRAIN, "the results of the column-loaded tiles");
        // Three tile pairs against a stalled result stream fill both banks.
        ready_mode = MODE_LOW;
        tiles_in   = '{0, 0};
        load_tiles(3, buf_ctrl_pkg::LAYOUT_ROW);
        fork
            send_lines(1'b0);
            send_lines(1'b1);
        join_none
        wait_for(WAIT_STALL, "both line streams to stall after two tile pairs");
        repeat (20) @(negedge clk);
        assert (!a_ready && !b_ready && tiles_in[0] == 2 && tiles_in[1] == 2)
            else fail_run("A third tile was taken while both banks were full.");
        ready_mode = MODE_HIGH;
        wait_for(WAIT_SENT, "the third tile pair to be accepted");
        wait_for(WAIT_DRAIN, "the results of the three stalled tile pairs");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
common/buf_ctrl_pkg.sv
common/mat_types_pkg.sv
common/line_stream_if.sv
tile_buffer/tile_buffer.sv
logic/tile_multiplier.sv
logic/matmul_tile_top.sv
testbench/matmul_tile_chk.sv
testbench/tb_matmul_tile.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_matmul_tile \
    -Mdir obj_dir \
    -f compile.f

output=$(./obj_dir/Vtb_matmul_tile 2>&1) || true
echo "$output"

if grep -qx "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
